//--- hdl/lcd_pkg.sv
/*
 * LCD constants, character codes, fixed menu text,
 * strobe timing, sequencer state codes and the LCD byte union
 */
package lcd_pkg;

    // ----------------------------------------
    // Frame geometry
    // ----------------------------------------
    localparam int FRAME_CHARS = 64;          // 4 lines x 16 chars
    localparam int HALF_CHARS  = 32;          // Lines 1+3, then lines 2+4
    localparam int CHAR_W      = 8;
    localparam int POS_W       = 6;

    // ----------------------------------------
    // Timing, in clocks of E
    // ----------------------------------------
    localparam int POWERUP_CYCLES = 64;
    localparam int EN_HIGH_CYCLES = 8;
    localparam int EN_LOW_CYCLES  = 8;
    localparam int PWR_CNT_W      = $clog2(POWERUP_CYCLES);
    localparam int PHASE_W        = $clog2(EN_HIGH_CYCLES + EN_LOW_CYCLES);

    // Character codes
    localparam logic [CHAR_W-1:0] CH_SPACE  = 8'h20;
    localparam logic [CHAR_W-1:0] CH_CURSOR = 8'h10;  // Right arrow in the CGROM
    localparam logic [CHAR_W-1:0] CH_BLOCK  = 8'hDB;
    localparam logic [CHAR_W-1:0] CH_ZERO   = 8'h30;  // ASCII '0'

    // Init commands, sent in this order
    localparam int N_INIT    = 9;
    localparam int CMD_IDX_W = $clog2(N_INIT);
    localparam logic [0:N_INIT-1][CHAR_W-1:0] INIT_CMDS = {
        8'h30, 8'h30, 8'h30,                  // Function set, 8-bit wake-up x3
        8'h01, 8'h02, 8'h06,                  // Clear, home, entry mode increment
        8'h0E, 8'h14, 8'h3C                   // Display on, cursor shift, 2-line 5x10
    };
    localparam logic [6:0] LINE2_ADDR = 7'h40;  // DDRAM start of line 2

    // Rate arithmetic, BPM = base + step * index
    localparam int RATE_BASE    = 30;
    localparam int RATE_STEP    = 5;
    localparam int RATE_MAX_IDX = 154;

    // Fixed menu text
    localparam logic [0:15][CHAR_W-1:0] TXT_TITLE = " LFO GENERATOR  ";
    localparam logic [0:6][CHAR_W-1:0]  TXT_RATE  = " RATE: ";
    localparam logic [0:4][CHAR_W-1:0]  TXT_BPM   = " BPM ";
    localparam logic [0:6][CHAR_W-1:0]  TXT_WAVE  = " WAVE: ";
    localparam logic [0:7][CHAR_W-1:0]  TXT_DEPTH = " DEPTH: ";
    localparam logic [0:5][0:7][CHAR_W-1:0] WAVE_NAMES = {
        "SINE    ", "SQUARE  ", "TRIANGLE", "RAMP UP ", "RAMPDOWN", "S & H   "
    };

    // Sequencer state codes
    localparam logic [2:0] ST_POWERUP = 3'd0;
    localparam logic [2:0] ST_INIT    = 3'd1;
    localparam logic [2:0] ST_FIRST   = 3'd2;
    localparam logic [2:0] ST_JUMP    = 3'd3;
    localparam logic [2:0] ST_SECOND  = 3'd4;
    localparam logic [2:0] ST_IDLE    = 3'd5;

    // One bus word, read as a character or as a set-DDRAM-address instruction
    typedef union packed {
        logic [CHAR_W-1:0] raw;
        struct packed {
            logic       set_addr;             // Bit 7, set-address opcode
            logic [6:0] addr;
        } instr;
    } lcd_byte_u;

    typedef logic [7:0] rate_idx_t;
    typedef logic [2:0] shape_t;
    typedef logic [2:0] depth_t;
    typedef logic [1:0] sel_t;

endpackage

//--- hdl/rate_digits.sv
/*
 * Rate index to three BPM characters, blank hundreds below 100
 */
module rate_digits (
    input  lcd_pkg::rate_idx_t               freq,
    output logic [0:2][lcd_pkg::CHAR_W-1:0]  digits   // [0] is hundreds
);
    import lcd_pkg::*;

    logic [9:0] rate;                         // Up to 800 BPM
    logic [3:0] hundreds;
    logic [3:0] tens;
    logic [3:0] units;

    // Out of range index falls back to the slowest rate
    always_comb begin
        if (freq > 8'(RATE_MAX_IDX)) begin
            rate = 10'(RATE_BASE);
        end else begin
            rate = 10'(RATE_BASE) + 10'(RATE_STEP) * 10'(freq);
        end
    end

    // Decimal split, constant divisors only
    assign hundreds = 4'(rate / 10'd100);
    assign tens     = 4'((rate / 10'd10) % 10'd10);
    assign units    = 4'(rate % 10'd10);

    always_comb begin
        if (rate < 10'd100) begin
            digits[0] = CH_SPACE;             // Leading blank
        end else begin
            digits[0] = CH_ZERO + CHAR_W'(hundreds);
        end
        digits[1] = CH_ZERO + CHAR_W'(tens);  // Never leading, rate >= 30
        digits[2] = CH_ZERO + CHAR_W'(units);
    end

endmodule

//--- hdl/menu_text.sv
/*
 * Menu frame character lookup by DDRAM order position,
 * cursor, wave name, rate digits and depth bar
 */
module menu_text (
    input  logic [lcd_pkg::POS_W-1:0] pos,
    input  lcd_pkg::sel_t             sel,
    input  lcd_pkg::shape_t           shape,
    input  lcd_pkg::depth_t           depth,
    input  lcd_pkg::rate_idx_t        freq,
    output lcd_pkg::lcd_byte_u        ch
);
    import lcd_pkg::*;

    logic [0:2][CHAR_W-1:0] rate_ch;          // Hundreds, tens, units
    logic [2:0]             wave_idx;
    logic [2:0]             n_blocks;
    logic [POS_W-1:0]       off;              // Offset inside a text field

    rate_digits rate_i (
        .freq   (freq),
        .digits (rate_ch)
    );

    // Unused shape codes show SINE
    assign wave_idx = (shape > 3'd5) ? 3'd0 : shape;

    // Bar length, capped back to one block past depth 4
    assign n_blocks = (depth > 3'd4) ? 3'd1 : depth + 3'd1;

    always_comb begin
        ch.raw = CH_SPACE;                    // Default blank
        off    = '0;
        case (pos) inside
            [6'd0:6'd15]: begin               // Line 1 title
                ch.raw = TXT_TITLE[pos[3:0]];
            end
            6'd16: begin                      // Rate cursor, sel 0 or 3
                if (sel == 2'd0 || sel == 2'd3) begin
                    ch.raw = CH_CURSOR;
                end
            end
            [6'd17:6'd23]: begin
                off    = pos - 6'd17;
                ch.raw = TXT_RATE[off[2:0]];
            end
            [6'd24:6'd26]: begin              // Rate value
                off    = pos - 6'd24;
                ch.raw = rate_ch[off[1:0]];
            end
            [6'd27:6'd31]: begin
                off    = pos - 6'd27;
                ch.raw = TXT_BPM[off[2:0]];
            end
            6'd32: begin                      // Wave cursor
                if (sel == 2'd1) begin
                    ch.raw = CH_CURSOR;
                end
            end
            [6'd33:6'd39]: begin
                off    = pos - 6'd33;
                ch.raw = TXT_WAVE[off[2:0]];
            end
            [6'd40:6'd47]: begin              // Wave name, blank padded
                off    = pos - 6'd40;
                ch.raw = WAVE_NAMES[wave_idx][off[2:0]];
            end
            6'd48: begin                      // Depth cursor
                if (sel == 2'd2) begin
                    ch.raw = CH_CURSOR;
                end
            end
            [6'd49:6'd56]: begin
                off    = pos - 6'd49;
                ch.raw = TXT_DEPTH[off[2:0]];
            end
            [6'd57:6'd61]: begin              // Depth bar, left aligned
                off = pos - 6'd57;
                if (off[2:0] < n_blocks) begin
                    ch.raw = CH_BLOCK;
                end
            end
            default: begin                    // 62..63 stay blank
                ch.raw = CH_SPACE;
            end
        endcase
    end

endmodule

//--- hdl/lcd_sequencer.sv
/*
 * LCD byte sequencer FSM: power-up wait, init commands,
 * two half frames around the line jump, single bus credit
 */
module lcd_sequencer (
    input  logic                      E,
    input  logic                      rst,
    output logic [lcd_pkg::POS_W-1:0] pos,
    input  lcd_pkg::lcd_byte_u        ch,
    input  logic                      credit_return,
    output logic                      issue,
    output lcd_pkg::lcd_byte_u        tx_byte,
    output logic                      is_data,
    output logic                      done
);
    import lcd_pkg::*;

    logic [2:0]           state;
    logic [PWR_CNT_W-1:0] pwr_cnt;            // Power-up wait
    logic [CMD_IDX_W-1:0] cmd_idx;            // Index into INIT_CMDS
    logic                 credit;             // One outstanding bus slot

    // ----------------------------------------
    // Byte selection
    // ----------------------------------------
    // Issue only with the credit in hand and a byte to send
    assign issue = credit && (state == ST_INIT || state == ST_FIRST ||
                              state == ST_JUMP || state == ST_SECOND);

    assign is_data = (state == ST_FIRST) || (state == ST_SECOND);

    always_comb begin
        tx_byte = ch;                         // Frame text by default
        case (state)
            ST_INIT: begin
                tx_byte.raw = INIT_CMDS[cmd_idx];
            end
            ST_JUMP: begin                    // Set DDRAM address, lines 2/4
                tx_byte.instr.set_addr = 1'b1;
                tx_byte.instr.addr     = LINE2_ADDR;
            end
            default: begin
                tx_byte = ch;
            end
        endcase
    end

    // ----------------------------------------
    // State and counters
    // ----------------------------------------
    always_ff @(posedge E or negedge rst) begin
        if (!rst) begin
            state   <= ST_POWERUP;
            pwr_cnt <= '0;
            cmd_idx <= '0;
            pos     <= '0;
            credit  <= 1'b1;                  // Strobe timer starts free
            done    <= 1'b0;
        end else begin
            // Spent on issue, given back at the end of the slot
            credit <= (credit && !issue) || credit_return;

            case (state)
                ST_POWERUP: begin
                    pwr_cnt <= pwr_cnt + 1'b1;
                    if (pwr_cnt == PWR_CNT_W'(POWERUP_CYCLES - 1)) begin
                        state <= ST_INIT;
                    end
                end
                ST_INIT: begin
                    if (issue) begin
                        if (cmd_idx == CMD_IDX_W'(N_INIT - 1)) begin
                            state <= ST_FIRST;
                        end else begin
                            cmd_idx <= cmd_idx + 1'b1;
                        end
                    end
                end
                ST_FIRST: begin               // Lines 1 and 3
                    if (issue) begin
                        pos <= pos + 1'b1;
                        if (pos == POS_W'(HALF_CHARS - 1)) begin
                            state <= ST_JUMP;
                        end
                    end
                end
                ST_JUMP: begin
                    if (issue) begin
                        state <= ST_SECOND;
                    end
                end
                ST_SECOND: begin              // Lines 2 and 4
                    if (issue) begin
                        if (pos == POS_W'(FRAME_CHARS - 1)) begin
                            state <= ST_IDLE;
                        end else begin
                            pos <= pos + 1'b1;
                        end
                    end
                end
                ST_IDLE: begin
                    // Last slot finished, frame complete until next reset
                    if (credit_return) begin
                        done <= 1'b1;
                    end
                end
                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

endmodule

//--- hdl/lcd_strobe.sv
/*
 * Bus slot timer: latches one byte, drives rs, data and the
 * lcd_en pulse, returns the credit in the last low cycle
 */
module lcd_strobe (
    input  logic                       E,
    input  logic                       rst,
    input  logic                       issue,
    input  lcd_pkg::lcd_byte_u         tx_byte,
    input  logic                       is_data,
    output logic                       lcd_en,
    output logic                       rs,
    output logic [lcd_pkg::CHAR_W-1:0] data,
    output logic                       credit_return
);
    import lcd_pkg::*;

    logic [PHASE_W-1:0] phase;                // 0..high-1 high, then low
    logic               busy;

    // Last low cycle of the slot
    assign credit_return = busy && (phase == PHASE_W'(EN_HIGH_CYCLES + EN_LOW_CYCLES - 1));

    always_ff @(posedge E or negedge rst) begin
        if (!rst) begin
            busy   <= 1'b0;
            phase  <= '0;
            lcd_en <= 1'b0;
            rs     <= 1'b0;
            data   <= '0;
        end else if (issue) begin
            busy   <= 1'b1;                   // New slot, lcd_en rises now
            phase  <= '0;
            lcd_en <= 1'b1;
            rs     <= is_data;
            data   <= tx_byte.raw;            // Held until the next issue
        end else if (busy) begin
            phase <= phase + 1'b1;
            if (phase == PHASE_W'(EN_HIGH_CYCLES - 1)) begin
                lcd_en <= 1'b0;               // Falling edge, LCD samples here
            end
            if (credit_return) begin
                busy  <= 1'b0;
                phase <= '0;
            end
        end
    end

endmodule

//--- hdl/lcd_top.sv
/*
 * LFO menu LCD driver top, text lookup, sequencer and strobe
 */
module lcd_top (
    input  logic                       E,
    input  logic                       rst,
    input  lcd_pkg::sel_t              sel,
    input  lcd_pkg::shape_t            shape,
    input  lcd_pkg::depth_t            depth,
    input  lcd_pkg::rate_idx_t         freq,
    output logic                       lcd_en,
    output logic                       rs,
    output logic                       rw,
    output logic [lcd_pkg::CHAR_W-1:0] data,
    output logic                       done
);
    import lcd_pkg::*;

    logic [POS_W-1:0] pos;                    // Frame position under lookup
    lcd_byte_u        ch;
    lcd_byte_u        tx_byte;
    logic             issue;
    logic             is_data;
    logic             credit_return;

    assign rw = 1'b0;                         // Write only, busy flag never read

    menu_text text_i (
        .pos   (pos),
        .sel   (sel),
        .shape (shape),
        .depth (depth),
        .freq  (freq),
        .ch    (ch)
    );

    lcd_sequencer seq_i (
        .E             (E),
        .rst           (rst),
        .pos           (pos),
        .ch            (ch),
        .credit_return (credit_return),
        .issue         (issue),
        .tx_byte       (tx_byte),
        .is_data       (is_data),
        .done          (done)
    );

    lcd_strobe strobe_i (
        .E             (E),
        .rst           (rst),
        .issue         (issue),
        .tx_byte       (tx_byte),
        .is_data       (is_data),
        .lcd_en        (lcd_en),
        .rs            (rs),
        .data          (data),
        .credit_return (credit_return)
    );

endmodule

//--- tb/lcd_assertions.sv
/*
 * Concurrent checks on lcd_en width, bus hold, credit use
 * and quiet bus after done, bound into the driver top
 */
module lcd_assertions (
    input logic                       E,
    input logic                       rst,
    input logic                       lcd_en,
    input logic                       rs,
    input logic [lcd_pkg::CHAR_W-1:0] data,
    input logic                       issue,
    input logic                       credit_return,
    input logic                       done
);
    import lcd_pkg::*;

    logic [4:0] hi_cnt;                           // Clocks with lcd_en high
    logic       credit;                           // Reference credit model

    always_ff @(posedge E or negedge rst) begin
        if (!rst) begin
            hi_cnt <= '0;
            credit <= 1'b1;
        end else begin
            hi_cnt <= lcd_en ? hi_cnt + 1'b1 : '0;
            credit <= (credit && !issue) || credit_return;
        end
    end

    en_width: assert property (@(posedge E) disable iff (!rst)
        $fell(lcd_en) |-> hi_cnt == 5'(EN_HIGH_CYCLES))
        else $error("lcd_en high phase shorter than EN_HIGH_CYCLES");

    en_overrun: assert property (@(posedge E) disable iff (!rst)
        lcd_en |-> hi_cnt < 5'(EN_HIGH_CYCLES))
        else $error("lcd_en high phase longer than EN_HIGH_CYCLES");

    bus_hold: assert property (@(posedge E) disable iff (!rst)
        $past(lcd_en) |-> $stable(rs) && $stable(data))
        else $error("rs or data moved while lcd_en was high");

    credit_use: assert property (@(posedge E) disable iff (!rst)
        issue |-> credit)
        else $error("issue pulsed without a credit");

    quiet_done: assert property (@(posedge E) disable iff (!rst)
        $rose(lcd_en) |-> !done)
        else $error("lcd_en rose after done");

endmodule

bind lcd_top lcd_assertions chk_i (
    .E             (E),
    .rst           (rst),
    .lcd_en        (lcd_en),
    .rs            (rs),
    .data          (data),
    .issue         (issue),
    .credit_return (credit_return),
    .done          (done)
);

//--- tb/lcd_tb.sv
/*
 * LFO menu LCD driver testbench with vector reader, bus monitor,
 * expected frame builder, compare tasks, watchdog and verdict
 */
module lcd_tb;
    import lcd_pkg::*;

    localparam int N_STROBES    = 74;             // 9 init + 32 + jump + 32
    localparam int SLOT_CYCLES  = 17;             // 16 clock slot plus reissue
    localparam int RESET_CYCLES = 5;
    localparam int QUIET_CYCLES = 2 * SLOT_CYCLES;  // Watch for stray strobes

    logic              E;
    logic              rst;
    sel_t              sel;
    shape_t            shape;
    depth_t            depth;
    rate_idx_t         freq;
    logic              lcd_en;
    logic              rs;
    logic              rw;
    logic [CHAR_W-1:0] data;
    logic              done;

    int v_sel[$];
    int v_shape[$];
    int v_depth[$];
    int v_freq[$];
    int v_bpm[$];                                 // Expected rate from the file
    int n_vec = 0;

    lcd_byte_u         cap_byte[$];               // Bytes seen on the bus
    logic              cap_rs[$];
    lcd_byte_u         exp_byte[N_STROBES];
    logic              exp_rs[N_STROBES];
    logic [CHAR_W-1:0] frame[FRAME_CHARS];        // Expected DDRAM order text
    logic [CHAR_W-1:0] init_ref[9] = '{8'h30, 8'h30, 8'h30, 8'h01, 8'h02,
                                      8'h06, 8'h0E, 8'h14, 8'h3C};

    int byte_errs  = 0;
    int count_errs = 0;
    int done_errs  = 0;

    lcd_top dut_i (
        .E      (E),
        .rst    (rst),
        .sel    (sel),
        .shape  (shape),
        .depth  (depth),
        .freq   (freq),
        .lcd_en (lcd_en),
        .rs     (rs),
        .rw     (rw),
        .data   (data),
        .done   (done)
    );

    always #4 E = ~E;                             // Period 8

    // ----------------------------------------
    // Bus monitor sampling on falling lcd_en
    // ----------------------------------------
    always @(negedge lcd_en) begin
        if (rst) begin
            cap_byte.push_back(data);
            cap_rs.push_back(rs);
            if (rw !== 1'b0) begin
                byte_errs++;
                $display("Fail %0t: rw not low during a strobe", $time);
            end
        end
    end

    // ----------------------------------------
    // Compare tasks
    // ----------------------------------------
    task automatic check_byte(input int idx, input lcd_byte_u got, input logic got_rs,
                              input lcd_byte_u want, input logic want_rs);
        if (got !== want || got_rs !== want_rs) begin
            byte_errs++;
            $display("Fail %0t: strobe %0d got rs=%b data=%02h, expected rs=%b data=%02h",
                     $time, idx, got_rs, got.raw, want_rs, want.raw);
        end
    endtask

    task automatic check_count(input int vec, input string when,
                               input int got, input int want);
        if (got != want) begin
            count_errs++;
            $display("Fail %0t: vector %0d gave %0d strobes %s, expected %0d",
                     $time, vec, got, when, want);
        end
    endtask

    task automatic expect_done(input int vec, input logic got, input logic want);
        if (got !== want) begin
            done_errs++;
            $display("Fail %0t: vector %0d done=%b, expected %b", $time, vec, got, want);
        end
    endtask

    // ----------------------------------------
    // Expected frame from the menu rules
    // ----------------------------------------
    task automatic put_text(input int at, input string s);
        for (int i = 0; i < s.len(); i++) begin
            frame[at + i] = s[i];
        end
    endtask

    function automatic string wave_name(input int shp);
        case (shp)
            1: return "SQUARE  ";
            2: return "TRIANGLE";
            3: return "RAMP UP ";
            4: return "RAMPDOWN";
            5: return "S & H   ";
            default: return "SINE    ";              // 0, 6 and 7
        endcase
    endfunction

    task automatic build_expected(input int s, input int shp, input int d, input int bpm);
        int n_blk;
        for (int k = 0; k < FRAME_CHARS; k++) begin
            frame[k] = 8'h20;
        end
        put_text(0, " LFO GENERATOR  ");
        put_text(17, " RATE: ");
        if (bpm < 100) begin
            frame[24] = 8'h20;                    // Leading blank
        end else begin
            frame[24] = 8'(8'h30 + bpm / 100);
        end
        frame[25] = 8'(8'h30 + (bpm / 10) % 10);
        frame[26] = 8'(8'h30 + bpm % 10);
        put_text(27, " BPM ");
        put_text(33, " WAVE: ");
        put_text(40, wave_name(shp));
        put_text(49, " DEPTH: ");
        case (s)
            1: frame[32] = 8'h10;
            2: frame[48] = 8'h10;
            default: frame[16] = 8'h10;           // Rate line for 0 and 3
        endcase
        n_blk = (d > 4) ? 1 : d + 1;
        for (int k = 0; k < n_blk; k++) begin
            frame[57 + k] = 8'hDB;
        end
        // Bus order is init, lines 1+3, jump to 0x40, lines 2+4
        for (int k = 0; k < 9; k++) begin
            exp_byte[k] = init_ref[k];
            exp_rs[k]   = 1'b0;
        end
        for (int k = 0; k < 32; k++) begin
            exp_byte[9 + k]  = frame[k];
            exp_rs[9 + k]    = 1'b1;
            exp_byte[42 + k] = frame[32 + k];
            exp_rs[42 + k]   = 1'b1;
        end
        exp_byte[41] = 8'hC0;
        exp_rs[41]   = 1'b0;
    endtask

    task automatic read_vectors();
        int    fd;
        int    n;
        int    s, shp, d, f, b;
        string line;
        fd = $fopen("tb/lcd_testdata.txt", "r");
        if (fd == 0) begin
            $display("Could not open tb/lcd_testdata.txt");
            return;
        end
        while (!$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            if (line.len() > 0 && line[0] != "#") begin  // Skip column notes
                n = $sscanf(line, "%d %d %d %d %d", s, shp, d, f, b);
                if (n == 5) begin
                    v_sel.push_back(s);
                    v_shape.push_back(shp);
                    v_depth.push_back(d);
                    v_freq.push_back(f);
                    v_bpm.push_back(b);
                end
            end
        end
        $fclose(fd);
    endtask

    task automatic run_vector(input int v);
        @(negedge E);
        rst   = 1'b0;
        sel   = sel_t'(v_sel[v]);
        shape = shape_t'(v_shape[v]);
        depth = depth_t'(v_depth[v]);
        freq  = rate_idx_t'(v_freq[v]);
        repeat (RESET_CYCLES) @(negedge E);
        expect_done(v, done, 1'b0);               // Cleared by reset
        cap_byte.delete();
        cap_rs.delete();
        rst = 1'b1;
        while (done !== 1'b1) begin
            @(negedge E);
        end
        check_count(v, "when done rose", cap_byte.size(), N_STROBES);
        repeat (QUIET_CYCLES) begin               // Done holds, no strobe follows
            @(negedge E);
            expect_done(v, done, 1'b1);
        end
        build_expected(v_sel[v], v_shape[v], v_depth[v], v_bpm[v]);
        check_count(v, "after done", cap_byte.size(), N_STROBES);
        for (int k = 0; k < N_STROBES && k < cap_byte.size(); k++) begin
            check_byte(k + 1, cap_byte[k], cap_rs[k], exp_byte[k], exp_rs[k]);
        end
    endtask

    // ----------------------------------------
    // Main sequence and verdict
    // ----------------------------------------
    initial begin
        E     = 1'b0;
        rst   = 1'b0;
        sel   = '0;
        shape = '0;
        depth = '0;
        freq  = '0;
        read_vectors();
        if (v_sel.size() == 0) begin
            count_errs++;
            $display("No test vectors were read, nothing was checked");
        end
        n_vec = v_sel.size();
        for (int v = 0; v < n_vec; v++) begin
            run_vector(v);
        end
        $display("Vectors %0d, byte errors %0d, strobe count errors %0d, done errors %0d",
                 n_vec, byte_errs, count_errs, done_errs);
        if (byte_errs == 0 && count_errs == 0 && done_errs == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

    // Watchdog sized from the frame length of every vector
    initial begin
        wait (n_vec > 0);
        repeat (n_vec * (RESET_CYCLES + POWERUP_CYCLES + N_STROBES * SLOT_CYCLES +
                         QUIET_CYCLES + 20)) @(posedge E);
        $display("Watchdog expired, the frames did not complete in time");
        $display("TEST FAILED");
        $finish;
    end

endmodule

//--- tb/lcd_testdata.txt
# Columns, decimal: sel shape depth freq expected_bpm
# expected_bpm is 30 + 5 * freq for freq up to 154, else 30
0 0 0 0 30
1 1 1 13 95
2 2 2 14 100
3 3 3 154 800
0 4 4 200 30
1 5 5 100 530
2 6 6 1 35
3 7 7 50 280
0 2 4 155 30
1 0 0 34 200
2 1 3 255 30
3 5 1 120 630

//--- all.f
hdl/lcd_pkg.sv
hdl/rate_digits.sv
hdl/menu_text.sv
hdl/lcd_sequencer.sv
hdl/lcd_strobe.sv
hdl/lcd_top.sv
tb/lcd_assertions.sv
tb/lcd_tb.sv

//--- run.sh
#!/bin/sh
# Build and run the LCD driver testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module lcd_tb -f all.f -o lcd_sim
./obj_dir/lcd_sim | tee sim.log

# Verdict comes from the log
if grep -qx "TEST PASSED" sim.log; then
    exit 0
fi
exit 1
